/* dcache_pkg.sv */
package dcache_pkg;

    // cpu word and address width
    localparam int DATA_W = 32;

    // access type from the cpu
    typedef enum logic [2:0] {
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB
    } ldst_op_t;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } cache_state_t;

    // addr[19:16] value of the uncached io window
    localparam logic [3:0] MMIO_CODE = 4'hf;

endpackage

/* dcache_ctrl.sv */
module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::DATA_W-1:0] addr,
    input  logic [dcache_pkg::DATA_W-1:0] write_data,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic                          hit,
    input  logic                          victim_dirty,
    input  logic [dcache_pkg::DATA_W-1:0] victim_addr,
    input  logic [dcache_pkg::DATA_W-1:0] victim_data,
    output logic                          stall,
    output logic                          line_we,
    output logic                          line_dirty,
    output logic                          use_mem,
    output logic [dcache_pkg::DATA_W-1:0] mem_addr,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    output logic                          mem_we,
    output logic                          mmio_sel
);
    import dcache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;
    logic         access;
    logic         uncached;
    logic         cached_req;

    assign access     = mem_read || mem_write;
    assign uncached   = (addr[19:16] == MMIO_CODE);
    assign cached_req = access && !uncached;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cached_req && !hit) begin
                    state_next = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: state_next = REFILL;
            REFILL:    state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // only an idle hit lets a cached request through
    assign stall = cached_req && (state != IDLE || !hit);

    // store hit, or the fill word at the end of a refill
    assign line_we    = (state == REFILL) || (state == IDLE && cached_req && hit && mem_write);
    assign line_dirty = mem_write;
    assign use_mem    = (state == REFILL) || (uncached && access);

    // victim goes out during write-back, the request address otherwise
    assign mem_addr  = (state == WRITEBACK) ? victim_addr : addr;
    assign mem_wdata = (state == WRITEBACK) ? victim_data : write_data;
    assign mem_we    = (state == WRITEBACK) || (state == IDLE && uncached && mem_write);
    assign mmio_sel  = uncached;

    assert property (@(posedge clk) disable iff (rst)
        (access && uncached) |-> (state == IDLE && !stall))
        else $error("uncached access stalled or met a busy controller");

    // the victim stays in place until the refill
    assert property (@(posedge clk) disable iff (rst)
        (state == WRITEBACK) |-> victim_dirty ##1 (state == REFILL))
        else $error("write-back without a dirty victim or not followed by refill");

endmodule

/* dcache_array.sv */
module dcache_array #(
    parameter int INDEX_W = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::DATA_W-1:0] addr,
    input  logic                          line_we,
    input  logic                          line_dirty,
    input  logic [dcache_pkg::DATA_W-1:0] line_word,
    output logic                          hit,
    output logic                          victim_dirty,
    output logic [dcache_pkg::DATA_W-1:0] cache_word,
    output logic [dcache_pkg::DATA_W-1:0] victim_addr,
    output logic [dcache_pkg::DATA_W-1:0] victim_data
);
    import dcache_pkg::*;

    localparam int DEPTH = 1 << INDEX_W;
    // tag covers addr[15:INDEX_W+2]
    localparam int TAG_W = 14 - INDEX_W;

    logic [DEPTH-1:0]   valid;
    logic [DEPTH-1:0]   dirty;
    logic [TAG_W-1:0]   tag_mem  [DEPTH];
    logic [DATA_W-1:0]  data_mem [DEPTH];

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   req_tag;
    logic               tag_eq;

    assign index   = addr[INDEX_W+1:2];
    assign req_tag = addr[15:INDEX_W+2];
    assign tag_eq  = (tag_mem[index] == req_tag);

    assign hit          = valid[index] && tag_eq;
    assign victim_dirty = valid[index] && dirty[index] && !tag_eq;
    assign cache_word   = data_mem[index];
    assign victim_data  = data_mem[index];
    // rebuild the victim word address below the io window
    assign victim_addr  = {{(DATA_W - 16){1'b0}}, tag_mem[index], index, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (line_we) begin
            valid[index] <= 1'b1;
            dirty[index] <= line_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[index]  <= req_tag;
            data_mem[index] <= line_word;
        end
    end

    // a dirty victim is replaced only after two stalled cycles (idle, write-back)
    assert property (@(posedge clk) disable iff (rst)
        (line_we && victim_dirty) |->
            $past(victim_dirty && !line_we, 1) && $past(victim_dirty && !line_we, 2))
        else $error("dirty line overwritten without write-back");

endmodule

/* ldst_align.sv */
module ldst_align (
    input  logic [dcache_pkg::DATA_W-1:0] addr,
    input  dcache_pkg::ldst_op_t          mem_op,
    input  logic [dcache_pkg::DATA_W-1:0] write_data,
    input  logic [dcache_pkg::DATA_W-1:0] cache_word,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
    input  logic                          use_mem,
    output logic [dcache_pkg::DATA_W-1:0] data_out,
    output logic [dcache_pkg::DATA_W-1:0] line_word
);
    import dcache_pkg::*;

    logic [DATA_W-1:0] src;
    logic [15:0]       half;
    logic [7:0]        byte_sel;

    assign src      = use_mem ? mem_rdata : cache_word;
    assign half     = addr[1] ? src[31:16] : src[15:0];
    assign byte_sel = src[8*addr[1:0] +: 8];

    // load extraction
    always_comb begin
        data_out = src;
        case (mem_op)
            LH:      data_out = {{16{half[15]}}, half};
            LHU:     data_out = {16'h0000, half};
            LB:      data_out = {{24{byte_sel[7]}}, byte_sel};
            LBU:     data_out = {24'h000000, byte_sel};
            default: data_out = src;
        endcase
    end

    // store merge into the source word
    always_comb begin
        line_word = src;
        case (mem_op)
            SW: line_word = write_data;
            SH: begin
                if (addr[1]) begin
                    line_word = {write_data[15:0], src[15:0]};
                end else begin
                    line_word = {src[31:16], write_data[15:0]};
                end
            end
            SB: line_word[8*addr[1:0] +: 8] = write_data[7:0];
            default: line_word = src;
        endcase
    end

    // no clock here, so checked after the delta settles
    always_comb begin
        if (use_mem) begin
            assert final (!$isunknown(mem_op))
                else $error("unknown mem_op during access");
        end
    end

endmodule

/* word_ram.sv */
module word_ram #(
    parameter int MEM_WORDS = 16384
) (
    input  logic                          clk,
    input  logic [dcache_pkg::DATA_W-1:0] mem_addr,
    input  logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    input  logic                          mem_we,
    input  logic                          mmio_sel,
    output logic [dcache_pkg::DATA_W-1:0] mem_rdata
);
    import dcache_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem  [MEM_WORDS];
    logic [DATA_W-1:0] mmio [16];
    logic [AW-1:0]     word_idx;
    logic [3:0]        mmio_idx;

    assign word_idx = mem_addr[AW+1:2];
    assign mmio_idx = mem_addr[5:2];

    // start from a zeroed image
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            mmio[i] = '0;
        end
    end

    assign mem_rdata = mmio_sel ? mmio[mmio_idx] : mem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            if (mmio_sel) begin
                mmio[mmio_idx] <= mem_wdata;
            end else begin
                mem[word_idx] <= mem_wdata;
            end
        end
    end

endmodule

/* dcache_top.sv */
module dcache_top #(
    parameter int INDEX_W   = 6,
    parameter int MEM_WORDS = 16384
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::DATA_W-1:0] addr,
    input  logic [dcache_pkg::DATA_W-1:0] write_data,
    input  dcache_pkg::ldst_op_t          mem_op,
    input  logic                          mem_read,
    input  logic                          mem_write,
    output logic [dcache_pkg::DATA_W-1:0] data_out,
    output logic                          stall
);
    import dcache_pkg::*;

    logic              hit;
    logic              victim_dirty;
    logic              line_we;
    logic              line_dirty;
    logic              use_mem;
    logic              mem_we;
    logic              mmio_sel;
    logic [DATA_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;
    logic [DATA_W-1:0] line_word;
    logic [DATA_W-1:0] cache_word;
    logic [DATA_W-1:0] victim_addr;
    logic [DATA_W-1:0] victim_data;

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .addr(addr), .write_data(write_data),
        .mem_read(mem_read), .mem_write(mem_write), .hit(hit),
        .victim_dirty(victim_dirty), .victim_addr(victim_addr),
        .victim_data(victim_data), .stall(stall), .line_we(line_we),
        .line_dirty(line_dirty), .use_mem(use_mem), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_we(mem_we), .mmio_sel(mmio_sel)
    );

    dcache_array #(.INDEX_W(INDEX_W)) u_array (
        .clk(clk), .rst(rst), .addr(addr), .line_we(line_we),
        .line_dirty(line_dirty), .line_word(line_word), .hit(hit),
        .victim_dirty(victim_dirty), .cache_word(cache_word),
        .victim_addr(victim_addr), .victim_data(victim_data)
    );

    ldst_align u_align (
        .addr(addr), .mem_op(mem_op), .write_data(write_data),
        .cache_word(cache_word), .mem_rdata(mem_rdata), .use_mem(use_mem),
        .data_out(data_out), .line_word(line_word)
    );

    word_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
        .clk(clk), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_we(mem_we), .mmio_sel(mmio_sel), .mem_rdata(mem_rdata)
    );

endmodule

/* tb_dcache.sv */
module tb_dcache;
    import dcache_pkg::*;

    localparam int RESET_CYCLES   = 8;
    // dirty miss takes idle, write-back, refill and the sampled hit cycle
    localparam int CYCLES_PER_VEC = 4;

    logic              clk;
    logic              rst;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] write_data;
    ldst_op_t          mem_op;
    logic              mem_read;
    logic              mem_write;
    logic [DATA_W-1:0] data_out;
    logic              stall;

    // access vectors from the input file
    logic [2:0]        vec_op    [$];
    logic [DATA_W-1:0] vec_addr  [$];
    logic [DATA_W-1:0] vec_wdata [$];
    logic [DATA_W-1:0] vec_exp   [$];

    int cycle_count = 0;
    int cycle_limit = 0;
    int vec_idx     = 0;
    int checks      = 0;
    int errors      = 0;

    dcache_top #(
        .INDEX_W(6),
        .MEM_WORDS(16384)
    ) uut (
        .clk(clk), .rst(rst), .addr(addr), .write_data(write_data),
        .mem_op(mem_op), .mem_read(mem_read), .mem_write(mem_write),
        .data_out(data_out), .stall(stall)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, vector %0d never completed",
                     cycle_count, vec_idx);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic idle_request();
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_op     = LW;
        addr       = '0;
        write_data = '0;
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        int                fields;
        logic [8*128-1:0]  line_buf;
        logic [DATA_W-1:0] f_op;
        logic [DATA_W-1:0] f_addr;
        logic [DATA_W-1:0] f_wdata;
        logic [DATA_W-1:0] f_exp;
        fd = $fopen("tb_dcache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_dcache_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            fields = 0;
            // comment and blank lines never scan as four fields
            if (n > 0) begin
                fields = $sscanf(line_buf, "%h %h %h %h", f_op, f_addr, f_wdata, f_exp);
            end
            if (fields == 4) begin
                vec_op.push_back(f_op[2:0]);
                vec_addr.push_back(f_addr);
                vec_wdata.push_back(f_wdata);
                vec_exp.push_back(f_exp);
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_vector(input int idx);
        ldst_op_t op;
        logic     store;
        logic     io;
        logic     ok;
        int       stalled;
        op      = ldst_op_t'(vec_op[idx]);
        store   = (op == SW) || (op == SH) || (op == SB);
        io      = (vec_addr[idx][19:16] == MMIO_CODE);
        ok      = 1'b1;
        stalled = 0;

        mem_op     = op;
        addr       = vec_addr[idx];
        write_data = vec_wdata[idx];
        mem_read   = !store;
        mem_write  = store;

        @(negedge clk);
        if (io) begin
            assert (!stall) else begin
                $display("stall went high on an uncached access at %0t", $time);
                errors++;
                ok = 1'b0;
            end
        end
        // request held until the cache lets it through
        while (stall) begin
            stalled++;
            @(negedge clk);
        end
        assert (stalled <= 2) else begin
            $display("stall held for %0d cycles, longer than a dirty miss, at %0t",
                     stalled, $time);
            errors++;
            ok = 1'b0;
        end

        if (!store) begin
            checks++;
            assert (data_out == vec_exp[idx]) else begin
                $display("ERR %0t data_out: got %h, expected %h",
                         $time, data_out, vec_exp[idx]);
                errors++;
                ok = 1'b0;
            end
        end

        idle_request();
        $display("vector %0d %s addr %h: %s", idx, op.name(), vec_addr[idx],
                 ok ? "ok" : "error");
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        idle_request();
        load_vectors();
        // one extra idle cycle follows reset
        cycle_limit = CYCLES_PER_VEC * vec_op.size() + RESET_CYCLES + 1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!stall) else begin
            $display("stall high with no request after reset at %0t", $time);
            errors++;
        end

        if (vec_op.size() == 0) begin
            $display("no access vectors were read");
            errors++;
        end
        for (vec_idx = 0; vec_idx < vec_op.size(); vec_idx++) begin
            run_vector(vec_idx);
        end

        $display("%0d vectors, %0d load checks, %0d errors", vec_op.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_dcache_input.txt */
# op addr wdata expect, all hex; op 0 LW 1 LH 2 LHU 3 LB 4 LBU 5 SW 6 SH 7 SB
# expect is compared on loads only, memory starts zeroed
5 00000040 8badf00d 00000000
0 00000040 00000000 8badf00d
0 00000044 00000000 00000000
5 00000080 7f809a12 00000000
3 00000080 00000000 00000012
4 00000080 00000000 00000012
3 00000081 00000000 ffffff9a
4 00000081 00000000 0000009a
3 00000082 00000000 ffffff80
4 00000082 00000000 00000080
3 00000083 00000000 0000007f
4 00000083 00000000 0000007f
1 00000080 00000000 ffff9a12
2 00000080 00000000 00009a12
1 00000082 00000000 00007f80
2 00000082 00000000 00007f80
5 000000c0 11223344 00000000
7 000000c0 000000aa 00000000
0 000000c0 00000000 112233aa
7 000000c3 000000cc 00000000
0 000000c0 00000000 cc2233aa
7 000000c1 ffffffbb 00000000
0 000000c0 00000000 cc22bbaa
7 000000c2 000000dd 00000000
0 000000c0 00000000 ccddbbaa
6 000000c0 12345678 00000000
0 000000c0 00000000 ccdd5678
6 000000c2 00009abc 00000000
0 000000c0 00000000 9abc5678
0 00000140 00000000 00000000
0 00000040 00000000 8badf00d
5 00000040 01020304 00000000
6 00000242 0000beef 00000000
2 00000242 00000000 0000beef
0 00000040 00000000 01020304
0 00000240 00000000 beef0000
5 000f0008 cafe0123 00000000
5 000f000c 00c0ffee 00000000
0 000f0008 00000000 cafe0123
3 000f000a 00000000 fffffffe
0 000f000c 00000000 00c0ffee
0 00000080 00000000 7f809a12
0 00000008 00000000 00000000

/* build.f */
dcache_pkg.sv
dcache_ctrl.sv
dcache_array.sv
ldst_align.sv
word_ram.sv
dcache_top.sv
tb_dcache.sv
